// File: source/despreadPkg.sv
// Register map, mode encoding and configuration structs for the dual-code despreader.
// Also the packed I/Q correlation result.

package despreadPkg;

    localparam logic [7:0] DespreadBase = 8'h4c;  // addr[11:4] of the despreader space.

    // Word indices, taken from addr[3:0].
    localparam logic [3:0] RegCtrl         = 4'd0;
    localparam logic [3:0] RegInitA        = 4'd1;
    localparam logic [3:0] RegTapsA        = 4'd2;
    localparam logic [3:0] RegRestartA     = 4'd3;
    localparam logic [3:0] RegIOutTapsA    = 4'd4;
    localparam logic [3:0] RegQOutTapsA    = 4'd5;
    localparam logic [3:0] RegInitB        = 4'd6;
    localparam logic [3:0] RegTapsB        = 4'd7;
    localparam logic [3:0] RegRestartB     = 4'd8;
    localparam logic [3:0] RegIOutTapsB    = 4'd9;
    localparam logic [3:0] RegQOutTapsB    = 4'd10;
    localparam logic [3:0] RegSymbolLength = 4'd11;

    localparam int RunBit   = 2;   // Position of run in RegCtrl.
    localparam int CodeBits = 18;
    localparam int CorrBits = 16;

    typedef enum logic [1:0] {
        ModeQuad     = 2'd0,  // Q code from A's Q taps.
        ModeDual     = 2'd1,  // Q code from B's I taps.
        ModeForward  = 2'd2,  // Q code from B's I taps.
        ModeReserved = 2'd3   // Behaves as ModeQuad.
    } despreadMode_t;

    typedef struct packed {
        logic [CodeBits-1:0] init;
        logic [CodeBits-1:0] polyTaps;
        logic [CodeBits-1:0] restartCount;
        logic [CodeBits-1:0] iOutTaps;
        logic [CodeBits-1:0] qOutTaps;
    } codeConfig_t;

    typedef struct packed {
        despreadMode_t mode;
        logic          run;
        codeConfig_t   codeA;
        codeConfig_t   codeB;
        logic [15:0]   symbolLength;
    } despreadConfig_t;

    typedef struct packed {
        logic signed [CorrBits-1:0] i;
        logic signed [CorrBits-1:0] q;
    } despreadCorr_t;

endpackage

// File: source/despreadRegs.sv
// Despreader configuration registers.
// Address decode, byte-lane writes and the read-back mux.

`timescale 1ns/1ns

module despreadRegs (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [11:0]                  addr,
    input  logic [31:0]                  din,
    input  logic                         wr0,
    input  logic                         wr1,
    input  logic                         wr2,
    input  logic                         wr3,
    output logic [31:0]                  dout,
    output despreadPkg::despreadConfig_t cfg,
    output logic                         cfgWrite
);

    localparam int FieldBits = despreadPkg::CodeBits;

    logic [3:0]  index;
    logic [3:0]  lanes;
    logic        selected;
    logic        write;
    logic [31:0] current;
    logic [31:0] merged;

    assign index    = addr[3:0];
    assign lanes    = {wr3, wr2, wr1, wr0};
    assign selected = addr[11:4] == despreadPkg::DespreadBase;
    assign write    = selected && (|lanes);

    always_comb begin
        case (index)
            despreadPkg::RegCtrl:         current = 32'({cfg.run, cfg.mode});
            despreadPkg::RegInitA:        current = 32'(cfg.codeA.init);
            despreadPkg::RegTapsA:        current = 32'(cfg.codeA.polyTaps);
            despreadPkg::RegRestartA:     current = 32'(cfg.codeA.restartCount);
            despreadPkg::RegIOutTapsA:    current = 32'(cfg.codeA.iOutTaps);
            despreadPkg::RegQOutTapsA:    current = 32'(cfg.codeA.qOutTaps);
            despreadPkg::RegInitB:        current = 32'(cfg.codeB.init);
            despreadPkg::RegTapsB:        current = 32'(cfg.codeB.polyTaps);
            despreadPkg::RegRestartB:     current = 32'(cfg.codeB.restartCount);
            despreadPkg::RegIOutTapsB:    current = 32'(cfg.codeB.iOutTaps);
            despreadPkg::RegQOutTapsB:    current = 32'(cfg.codeB.qOutTaps);
            despreadPkg::RegSymbolLength: current = 32'(cfg.symbolLength);
            default:                      current = '0;
        endcase
    end

    // Lanes without a strobe keep the register's present contents.
    always_comb begin
        for (int lane = 0; lane < 4; lane++) begin
            merged[lane*8 +: 8] = lanes[lane] ? din[lane*8 +: 8] : current[lane*8 +: 8];
        end
    end

    assign dout = selected ? current : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg      <= '0;
            cfgWrite <= 1'b0;
        end else begin
            cfgWrite <= write;
            if (write) begin
                case (index)
                    despreadPkg::RegCtrl: begin
                        cfg.mode <= despreadPkg::despreadMode_t'(merged[1:0]);
                        cfg.run  <= merged[despreadPkg::RunBit];
                    end
                    despreadPkg::RegInitA:        cfg.codeA.init         <= merged[FieldBits-1:0];
                    despreadPkg::RegTapsA:        cfg.codeA.polyTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegRestartA:     cfg.codeA.restartCount <= merged[FieldBits-1:0];
                    despreadPkg::RegIOutTapsA:    cfg.codeA.iOutTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegQOutTapsA:    cfg.codeA.qOutTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegInitB:        cfg.codeB.init         <= merged[FieldBits-1:0];
                    despreadPkg::RegTapsB:        cfg.codeB.polyTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegRestartB:     cfg.codeB.restartCount <= merged[FieldBits-1:0];
                    despreadPkg::RegIOutTapsB:    cfg.codeB.iOutTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegQOutTapsB:    cfg.codeB.qOutTaps     <= merged[FieldBits-1:0];
                    despreadPkg::RegSymbolLength: cfg.symbolLength       <= merged[15:0];
                    default: ;
                endcase
            end
        end
    end

    // Unmapped indices inside the space must not disturb any register.
    assert property (@(posedge clk) disable iff (reset)
        (write && index > despreadPkg::RegSymbolLength) |=> cfg == $past(cfg));

endmodule

// File: source/chipTimer.sv
// Chip and symbol timing.
// Sample-phase counter for the chip strobe, chip counter for the symbol end.

`timescale 1ns/1ns

module chipTimer #(
    parameter int SamplesPerChip = 2
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clkEn,
    input  logic        running,
    input  logic        codeLoad,
    input  logic [15:0] symbolLength,
    output logic        chipEn,
    output logic        symbolEnd
);

    localparam int PhaseBits = SamplesPerChip > 1 ? $clog2(SamplesPerChip) : 1;
    localparam logic [PhaseBits-1:0] LastPhase = PhaseBits'(SamplesPerChip - 1);

    logic [PhaseBits-1:0] phase;
    logic [15:0]          chipCount;
    logic [15:0]          lastChip;
    logic                 chipDone;
    logic                 symbolDone;

    assign lastChip   = (symbolLength == 16'd0) ? 16'd0 : symbolLength - 16'd1;  // Zero means one.
    assign chipDone   = clkEn && phase == LastPhase;
    assign symbolDone = chipCount == lastChip;

    always_ff @(posedge clk) begin
        if (reset || codeLoad || !running) begin
            phase     <= '0;
            chipCount <= '0;
            chipEn    <= 1'b0;
            symbolEnd <= 1'b0;
        end else begin
            chipEn    <= chipDone;
            symbolEnd <= chipDone && symbolDone;
            if (clkEn) begin
                phase <= chipDone ? '0 : phase + 1'b1;
            end
            if (chipDone) begin
                chipCount <= symbolDone ? 16'd0 : chipCount + 16'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) symbolEnd |-> chipEn);

endmodule

// File: source/despreadControl.sv
// Despreader sequencing FSM.
// Loads the code generators when run rises and aborts on any reconfiguration.

`timescale 1ns/1ns

module despreadControl (
    input  logic clk,
    input  logic reset,
    input  logic run,
    input  logic cfgWrite,
    output logic codeLoad,
    output logic running
);

    typedef enum logic [1:0] {
        Idle = 2'd0,
        Load = 2'd1,
        Run  = 2'd2
    } state_t;

    state_t state;
    logic   runDelayed;
    logic   runRise;

    assign runRise  = run && !runDelayed;
    assign codeLoad = state == Load;
    assign running  = state == Run;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= Idle;
            runDelayed <= 1'b0;
        end else begin
            runDelayed <= run;
            case (state)
                Idle: begin
                    if (runRise) begin
                        state <= Load;
                    end
                end
                Load: state <= (run && !cfgWrite) ? Run : Idle;
                Run: begin
                    // A new setting invalidates the codes in flight.
                    if (!run || cfgWrite) begin
                        state <= Idle;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Generators are loaded for exactly one cycle per start.
    assert property (@(posedge clk) disable iff (reset) codeLoad |=> !codeLoad);

endmodule

// File: source/codeGenerator.sv
// Programmable PN code generator.
// LFSR with I and Q output tap parity and a restart count.

`timescale 1ns/1ns

module codeGenerator #(
    parameter int CodeWidth = 18
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     chipEn,
    input  logic                     codeLoad,
    input  despreadPkg::codeConfig_t cfg,
    output logic                     iOut,
    output logic                     qOut
);

    logic [CodeWidth-1:0] state;
    logic [CodeWidth-1:0] chipCount;
    logic                 feedback;
    logic                 restart;

    assign feedback = ^(state & cfg.polyTaps[CodeWidth-1:0]);
    assign restart  = chipCount == cfg.restartCount[CodeWidth-1:0];

    // Output codes are the parity of the tapped state bits.
    assign iOut = ^(state & cfg.iOutTaps[CodeWidth-1:0]);
    assign qOut = ^(state & cfg.qOutTaps[CodeWidth-1:0]);

    always_ff @(posedge clk) begin
        if (reset || codeLoad) begin
            state     <= cfg.init[CodeWidth-1:0];
            chipCount <= '0;
        end else if (chipEn) begin
            if (restart) begin
                state     <= cfg.init[CodeWidth-1:0];  // Back to the start of the sequence.
                chipCount <= '0;
            end else begin
                state     <= {state[CodeWidth-2:0], feedback};
                chipCount <= chipCount + 1'b1;
            end
        end
    end

endmodule

// File: source/despreadCorrelator.sv
// I/Q correlator.
// Sample hold, soft-decision mapping, Q code selection and accumulate-and-dump.

`timescale 1ns/1ns

module despreadCorrelator #(
    parameter int CorrWidth = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clkEn,
    input  logic                       chipEn,
    input  logic                       symbolEnd,
    input  logic                       running,
    input  despreadPkg::despreadMode_t mode,
    input  logic [17:0]                iIn,
    input  logic [17:0]                qIn,
    input  logic                       iOutA,
    input  logic                       qOutA,
    input  logic                       iOutB,
    output logic                       iCode,
    output logic                       qCode,
    output despreadPkg::despreadCorr_t corr,
    output logic                       corrValid
);

    localparam int OutBits = $bits(despreadPkg::despreadCorr_t) / 2;

    logic [3:0]                  iTop;
    logic [3:0]                  qTop;
    logic signed [2:0]           iSoft;
    logic signed [2:0]           qSoft;
    logic                        qSelect;
    logic signed [CorrWidth-1:0] iAcc;
    logic signed [CorrWidth-1:0] qAcc;
    logic signed [CorrWidth-1:0] iSum;
    logic signed [CorrWidth-1:0] qSum;

    // Half of v plus one, rounded down, clamped to +-3.
    function automatic logic signed [2:0] softValue(input logic [3:0] top);
        logic signed [4:0] half;
        half = ($signed({top[3], top}) + 5'sd1) >>> 1;
        if (half > 5'sd3) begin
            return 3'sd3;
        end
        if (half < -5'sd3) begin
            return -3'sd3;
        end
        return half[2:0];
    endfunction

    always_ff @(posedge clk) begin
        if (clkEn) begin
            iTop <= iIn[17:14];
            qTop <= qIn[17:14];
        end
    end

    assign iSoft   = softValue(iTop);
    assign qSoft   = softValue(qTop);
    assign qSelect = (mode == despreadPkg::ModeDual || mode == despreadPkg::ModeForward) ?
                     iOutB : qOutA;

    // A code bit of one inverts the chip.
    assign iSum = iAcc + (iOutA ? -CorrWidth'(iSoft) : CorrWidth'(iSoft));
    assign qSum = qAcc + (qSelect ? -CorrWidth'(qSoft) : CorrWidth'(qSoft));

    always_ff @(posedge clk) begin
        if (reset) begin
            iCode     <= 1'b0;
            qCode     <= 1'b0;
            iAcc      <= '0;
            qAcc      <= '0;
            corr      <= '0;
            corrValid <= 1'b0;
        end else begin
            corrValid <= running && chipEn && symbolEnd;
            if (!running) begin
                iAcc <= '0;
                qAcc <= '0;
            end else if (chipEn) begin
                iCode <= iOutA;
                qCode <= qSelect;
                if (symbolEnd) begin
                    corr.i <= OutBits'(iSum);  // Dump includes the last chip.
                    corr.q <= OutBits'(qSum);
                    iAcc   <= '0;
                    qAcc   <= '0;
                end else begin
                    iAcc <= iSum;
                    qAcc <= qSum;
                end
            end
        end
    end

endmodule

// File: source/dualDespreader.sv
// Dual-code despreader top level.
// Registers, control FSM, chip timer, two code generators and the correlator.

`timescale 1ns/1ns

module dualDespreader #(
    parameter int CodeWidth      = 18,
    parameter int SamplesPerChip = 2,
    parameter int CorrWidth      = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clkEn,
    input  logic                       wr0,
    input  logic                       wr1,
    input  logic                       wr2,
    input  logic                       wr3,
    input  logic [11:0]                addr,
    input  logic [31:0]                din,
    input  logic [17:0]                iIn,
    input  logic [17:0]                qIn,
    output logic [31:0]                dout,
    output despreadPkg::despreadMode_t despreadMode,
    output logic                       iCode,
    output logic                       qCode,
    output despreadPkg::despreadCorr_t corr,
    output logic                       corrValid
);

    despreadPkg::despreadConfig_t cfg;
    logic                         cfgWrite;
    logic                         codeLoad;
    logic                         running;
    logic                         chipEn;
    logic                         symbolEnd;
    logic                         iOutA;
    logic                         qOutA;
    logic                         iOutB;

    assign despreadMode = cfg.mode;

    despreadRegs regs (
        .clk(clk), .reset(reset), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout), .cfg(cfg), .cfgWrite(cfgWrite)
    );

    despreadControl control (
        .clk(clk), .reset(reset), .run(cfg.run), .cfgWrite(cfgWrite),
        .codeLoad(codeLoad), .running(running)
    );

    chipTimer #(.SamplesPerChip(SamplesPerChip)) timer (
        .clk(clk), .reset(reset), .clkEn(clkEn), .running(running), .codeLoad(codeLoad),
        .symbolLength(cfg.symbolLength), .chipEn(chipEn), .symbolEnd(symbolEnd)
    );

    codeGenerator #(.CodeWidth(CodeWidth)) codeA (
        .clk(clk), .reset(reset), .chipEn(chipEn), .codeLoad(codeLoad),
        .cfg(cfg.codeA), .iOut(iOutA), .qOut(qOutA)
    );

    // Only B's I output is used, as the Q code of the dual-code modes.
    codeGenerator #(.CodeWidth(CodeWidth)) codeB (
        .clk(clk), .reset(reset), .chipEn(chipEn), .codeLoad(codeLoad),
        .cfg(cfg.codeB), .iOut(iOutB), .qOut()
    );

    despreadCorrelator #(.CorrWidth(CorrWidth)) correlator (
        .clk(clk), .reset(reset), .clkEn(clkEn), .chipEn(chipEn), .symbolEnd(symbolEnd),
        .running(running), .mode(cfg.mode), .iIn(iIn), .qIn(qIn),
        .iOutA(iOutA), .qOutA(qOutA), .iOutB(iOutB),
        .iCode(iCode), .qCode(qCode), .corr(corr), .corrValid(corrValid)
    );

endmodule

// File: testbench/despreadTb.sv
// Testbench for the dual-code despreader.
// Directed tests with reference LFSR, soft-mapping and correlator models, clock, reset, watchdog.

`timescale 1ns/1ns

module despreadTb;

    localparam int ClockPeriod      = 100;
    localparam int ResetCycles      = 16;
    localparam int DriveDelay       = 10;
    localparam int MaxGap           = 3;
    localparam int CodeChips        = 40;
    localparam int SymbolsPerLength = 6;
    localparam int AbortChips       = 24;
    localparam int CyclesPerChip    = 2 * (MaxGap + 1) + 1;
    localparam int TestChips        = 4 * CodeChips + SymbolsPerLength * 22 + AbortChips;
    localparam int WatchdogCycles   = 3 * ResetCycles + 600 + 2 * TestChips * CyclesPerChip;

    logic                       clk;
    logic                       reset;
    logic                       clkEn;
    logic                       wr0;
    logic                       wr1;
    logic                       wr2;
    logic                       wr3;
    logic [11:0]                addr;
    logic [31:0]                din;
    logic [17:0]                iIn;
    logic [17:0]                qIn;
    logic [31:0]                dout;
    despreadPkg::despreadMode_t despreadMode;
    logic                       iCode;
    logic                       qCode;
    despreadPkg::despreadCorr_t corr;
    logic                       corrValid;

    // Reference model state.
    despreadPkg::codeConfig_t codeCfg [2];
    logic [17:0]              lfsrState [2];
    logic [17:0]              lfsrCount [2];
    logic [1:0]               modelMode;
    logic                     expectICode;
    logic                     expectQCode;
    int                       accI;
    int                       accQ;
    int                       onTimeCount;
    int                       validCount;
    int                       errorCount;

    dualDespreader dualDespreader_i (
        .clk(clk), .reset(reset), .clkEn(clkEn),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3), .addr(addr), .din(din),
        .iIn(iIn), .qIn(qIn), .dout(dout), .despreadMode(despreadMode),
        .iCode(iCode), .qCode(qCode), .corr(corr), .corrValid(corrValid)
    );

    initial clk = 1'b0;
    always #(ClockPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        if (corrValid) begin
            validCount++;
        end
    end

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got === expected) else begin
            $display("error: %s got %h expected %h", name, got, expected);
            errorCount++;
        end
    endtask

    function automatic logic [11:0] regAddress(input logic [3:0] index);
        return {despreadPkg::DespreadBase, index};
    endfunction

    function automatic logic [31:0] fieldMask(input int index);
        if (index == 0) begin
            return 32'h7;  // Mode and run.
        end
        if (index == 11) begin
            return 32'hffff;
        end
        return 32'h3ffff;
    endfunction

    task automatic writeBus(input logic [11:0] address, input logic [31:0] data,
                            input logic [3:0] strobes);
        addr = address;
        din  = data;
        {wr3, wr2, wr1, wr0} = strobes;
        @(posedge clk);
        #DriveDelay;
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic readBus(input logic [11:0] address, output logic [31:0] data);
        addr = address;
        #(ClockPeriod / 2);
        data = dout;
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        reset = 1'b0;
    endtask

    // Floor of (v + 1) / 2 with v the signed top nibble, limited to +-3.
    function automatic int softLevel(input logic [3:0] top);
        int v;
        int s;
        int level;
        v = (top >= 4'd8) ? int'(top) - 16 : int'(top);
        s = v + 1;
        level = (s < 0) ? (s - 1) / 2 : s / 2;
        if (level > 3) begin
            level = 3;
        end
        if (level < -3) begin
            level = -3;
        end
        return level;
    endfunction

    function automatic void advanceCodes();
        for (int g = 0; g < 2; g++) begin
            if (lfsrCount[g] == codeCfg[g].restartCount) begin
                lfsrState[g] = codeCfg[g].init;
                lfsrCount[g] = '0;
            end else begin
                lfsrState[g] = {lfsrState[g][16:0], ^(lfsrState[g] & codeCfg[g].polyTaps)};
                lfsrCount[g] = lfsrCount[g] + 18'd1;
            end
        end
    endfunction

    function automatic despreadPkg::codeConfig_t randomCode(input logic [17:0] restart);
        despreadPkg::codeConfig_t code;
        code.init         = 18'($urandom) | 18'd1;
        code.polyTaps     = 18'($urandom) | 18'h20000;
        code.restartCount = restart;
        code.iOutTaps     = 18'($urandom) | 18'd1;
        code.qOutTaps     = 18'($urandom) | 18'h00100;
        return code;
    endfunction

    // Idle cycles carry random data that the DUT must ignore.
    task automatic driveSample(input logic [17:0] iValue, input logic [17:0] qValue);
        int gap;
        gap = $urandom_range(MaxGap, 0);
        repeat (gap) begin
            iIn = 18'($urandom);
            qIn = 18'($urandom);
            @(posedge clk);
            #DriveDelay;
        end
        clkEn = 1'b1;
        iIn   = iValue;
        qIn   = qValue;
        @(posedge clk);
        #DriveDelay;
        clkEn = 1'b0;
    endtask

    task automatic driveChip();
        logic [3:0] iTop;
        logic [3:0] qTop;
        iTop = 4'(onTimeCount);
        qTop = 4'(onTimeCount * 7);
        onTimeCount++;
        driveSample(18'($urandom), 18'($urandom));
        driveSample({iTop, 14'($urandom)}, {qTop, 14'($urandom)});  // On-time sample.
        expectICode = ^(lfsrState[0] & codeCfg[0].iOutTaps);
        if (modelMode == 2'd1 || modelMode == 2'd2) begin
            expectQCode = ^(lfsrState[1] & codeCfg[1].iOutTaps);
        end else begin
            expectQCode = ^(lfsrState[0] & codeCfg[0].qOutTaps);
        end
        accI += expectICode ? -softLevel(iTop) : softLevel(iTop);
        accQ += expectQCode ? -softLevel(qTop) : softLevel(qTop);
        advanceCodes();
    endtask

    task automatic configureDespreader(input logic [1:0] mode, input logic [15:0] length,
                                       input despreadPkg::codeConfig_t codeA,
                                       input despreadPkg::codeConfig_t codeB);
        writeBus(regAddress(despreadPkg::RegCtrl), {30'd0, mode}, 4'hf);
        writeBus(regAddress(despreadPkg::RegInitA), 32'(codeA.init), 4'hf);
        writeBus(regAddress(despreadPkg::RegTapsA), 32'(codeA.polyTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegRestartA), 32'(codeA.restartCount), 4'hf);
        writeBus(regAddress(despreadPkg::RegIOutTapsA), 32'(codeA.iOutTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegQOutTapsA), 32'(codeA.qOutTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegInitB), 32'(codeB.init), 4'hf);
        writeBus(regAddress(despreadPkg::RegTapsB), 32'(codeB.polyTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegRestartB), 32'(codeB.restartCount), 4'hf);
        writeBus(regAddress(despreadPkg::RegIOutTapsB), 32'(codeB.iOutTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegQOutTapsB), 32'(codeB.qOutTaps), 4'hf);
        writeBus(regAddress(despreadPkg::RegSymbolLength), 32'(length), 4'hf);
        codeCfg[0] = codeA;
        codeCfg[1] = codeB;
        modelMode  = mode;
    endtask

    // Run rises, then Load for a cycle; the timer counts from the third cycle on.
    task automatic startRun();
        writeBus(regAddress(despreadPkg::RegCtrl), {29'd0, 1'b1, modelMode}, 4'hf);
        repeat (3) begin
            @(posedge clk);
            #DriveDelay;
        end
        for (int g = 0; g < 2; g++) begin
            lfsrState[g] = codeCfg[g].init;
            lfsrCount[g] = '0;
        end
        accI = 0;
        accQ = 0;
    endtask

    task automatic checkCodes();
        @(posedge clk);
        #DriveDelay;
        compareValue("iCode", 32'(iCode), 32'(expectICode));
        compareValue("qCode", 32'(qCode), 32'(expectQCode));
    endtask

    task automatic checkSymbol();
        logic seen;
        seen = 1'b0;
        for (int w = 0; w < 4 && !seen; w++) begin
            @(posedge clk);
            #DriveDelay;
            seen = corrValid;
        end
        assert (seen) else begin
            $display("corrValid did not pulse after the last chip of a symbol");
            errorCount++;
        end
        if (seen) begin
            compareValue("corr.i", {16'd0, corr.i}, {16'd0, 16'(accI)});
            compareValue("corr.q", {16'd0, corr.q}, {16'd0, 16'(accQ)});
        end
        accI = 0;
        accQ = 0;
    endtask

    task automatic registerAccess();
        logic [31:0] shadow [12];
        logic [31:0] data;
        logic [31:0] merged;
        logic [31:0] got;
        logic [3:0]  strobes;
        for (int r = 0; r < 12; r++) begin
            shadow[r] = '0;
        end
        for (int pass = 0; pass < 3; pass++) begin
            for (int r = 0; r < 12; r++) begin
                data    = $urandom;
                strobes = 4'($urandom);
                for (int b = 0; b < 4; b++) begin
                    merged[b*8 +: 8] = strobes[b] ? data[b*8 +: 8] : shadow[r][b*8 +: 8];
                end
                shadow[r] = merged & fieldMask(r);
                writeBus(regAddress(4'(r)), data, strobes);
                readBus(regAddress(4'(r)), got);
                compareValue($sformatf("dout[%0d]", r), got, shadow[r]);
                compareValue("despreadMode", 32'(despreadMode), {30'd0, shadow[0][1:0]});
            end
        end
        // Unmapped indices and foreign addresses neither store nor read back.
        for (int r = 12; r < 16; r++) begin
            writeBus(regAddress(4'(r)), $urandom, 4'hf);
            readBus(regAddress(4'(r)), got);
            compareValue($sformatf("dout[%0d]", r), got, 32'd0);
        end
        for (int n = 0; n < 8; n++) begin
            addr = {despreadPkg::DespreadBase ^ 8'($urandom_range(255, 1)), 4'($urandom)};
            writeBus(addr, $urandom, 4'hf);
            readBus(addr, got);
            compareValue("dout foreign", got, 32'd0);
        end
        for (int r = 0; r < 12; r++) begin
            readBus(regAddress(4'(r)), got);
            compareValue($sformatf("dout[%0d]", r), got, shadow[r]);
        end
        writeBus(regAddress(despreadPkg::RegCtrl), 32'd0, 4'hf);
    endtask

    task automatic resetState();
        logic [31:0] got;
        applyReset();
        for (int r = 0; r < 16; r++) begin
            readBus(regAddress(4'(r)), got);
            compareValue($sformatf("dout[%0d]", r), got, 32'd0);
        end
        compareValue("corrValid", 32'(corrValid), 32'd0);
        compareValue("iCode", 32'(iCode), 32'd0);
        compareValue("qCode", 32'(qCode), 32'd0);
        compareValue("corr", 32'(corr), 32'd0);
    endtask

    task automatic codeSequences();
        for (int m = 0; m < 4; m++) begin
            configureDespreader(2'(m), 16'd1000, randomCode(18'd7 + 18'(m)), randomCode(18'd12));
            startRun();
            for (int c = 0; c < CodeChips; c++) begin
                driveChip();
                checkCodes();
            end
        end
    endtask

    task automatic correlationSums();
        int lengths [3];
        int modes [3];
        int startCount;
        lengths = '{1, 5, 16};
        modes   = '{3, 1, 2};
        for (int n = 0; n < 3; n++) begin
            configureDespreader(2'(modes[n]), 16'(lengths[n]), randomCode(18'd30),
                                randomCode(18'd9));
            startRun();
            startCount = validCount;
            for (int s = 0; s < SymbolsPerLength; s++) begin
                for (int c = 0; c < lengths[n]; c++) begin
                    driveChip();
                end
                checkSymbol();
            end
            @(posedge clk);
            #DriveDelay;
            compareValue("corrValid pulses", 32'(validCount - startCount), SymbolsPerLength);
        end
    endtask

    task automatic reconfigurationAbort();
        int startCount;
        configureDespreader(2'd1, 16'd5, randomCode(18'd20), randomCode(18'd6));
        startRun();
        repeat (3) driveChip();
        writeBus(regAddress(despreadPkg::RegSymbolLength), 32'd5, 4'hf);
        startCount = validCount;
        repeat (10) driveChip();
        @(posedge clk);
        #DriveDelay;
        assert (validCount == startCount) else begin
            $display("corrValid pulsed after a register write aborted the run");
            errorCount++;
        end
        writeBus(regAddress(despreadPkg::RegCtrl), {30'd0, modelMode}, 4'hf);
        startRun();
        driveChip();
        checkCodes();
        repeat (4) driveChip();
        checkSymbol();
    endtask

    initial begin
        void'($urandom(32'h375e_98e3));
        reset       = 1'b1;
        clkEn       = 1'b0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        addr        = '0;
        din         = '0;
        iIn         = '0;
        qIn         = '0;
        errorCount  = 0;
        validCount  = 0;
        onTimeCount = 0;
        accI        = 0;
        accQ        = 0;
        applyReset();
        registerAccess();
        resetState();
        codeSequences();
        correlationSums();
        reconfigurationAbort();
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClockPeriod);
        $display("watchdog timeout, the tests did not complete in time");
        $display("tests failed");
        $finish;
    end

endmodule

// File: compile.f
source/despreadPkg.sv
source/despreadRegs.sv
source/chipTimer.sv
source/despreadControl.sv
source/codeGenerator.sv
source/despreadCorrelator.sv
source/dualDespreader.sv
testbench/despreadTb.sv

// File: run.sh
#!/bin/sh
# Builds the despreader testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module despreadTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VdespreadTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "tests failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
